// ==== efi_argument_decoder.sv ====
// efi_argument_decoder: loads the argument stream into the sort engine storage and issues start

`timescale 1ns/1ps
`include "efi_sorter_macros.svh"

module efi_argument_decoder (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      arg_valid,
    output logic                      arg_ready,
    input  efi_sorter_pkg::efi_word_t arg_data,
    input  efi_sorter_pkg::efi_dest_t arg_dest,
    input  logic                      arg_last,
    efi_load_if.decoder               load
);

    localparam efi_sorter_pkg::efi_length_t MAX_LENGTH = `EFI_MAX_LENGTH;

    // number of words stored so far, which saturates at the storage size
    efi_sorter_pkg::efi_length_t count;
    efi_sorter_pkg::efi_length_t length_q;
    efi_sorter_pkg::efi_dest_t   dest_q;
    logic                        start_q;
    logic                        arg_fire;
    logic                        room;

    assign arg_fire = arg_valid && arg_ready;
    assign room = (count != MAX_LENGTH);

    // the storage belongs to the engine from start until the streamer releases it
    assign arg_ready = !load.busy && !start_q;

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
            start_q <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (arg_fire) begin
                if (arg_last) begin
                    count <= '0;
                    start_q <= 1'b1;
                end else if (room) begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // destination of the first word and length of the batch as handed to the engine
    always_ff @(posedge clock) begin
        if (arg_fire && (count == '0)) begin
            dest_q <= arg_dest;
        end
        if (arg_fire && arg_last) begin
            // words past the storage size were dropped, so clip the length there
            length_q <= room ? count + 1'b1 : count;
        end
    end

    // every accepted word is written in its own cycle and overflow words never reach the storage
    assign load.wr_en = arg_fire && room;
    assign load.wr_index = efi_sorter_pkg::efi_index_t'(count);
    assign load.wr_data = arg_data;
    assign load.start = start_q;
    assign load.length = length_q;
    assign load.dest = dest_q;

endmodule

// ==== efi_result_streamer.sv ====
// efi_result_streamer: streams the sorted batch out of the engine storage under back-pressure

`timescale 1ns/1ps

module efi_result_streamer (
    input  logic                       clock,
    input  logic                       reset,
    efi_read_if.streamer               read,
    output logic                       res_valid,
    input  logic                       res_ready,
    output efi_sorter_pkg::efi_word_t  res_data,
    output efi_sorter_pkg::efi_dest_t  res_dest,
    output logic                       res_last
);

    logic                       active;
    efi_sorter_pkg::efi_index_t rd_index;
    logic                       release_q;
    logic                       last_word;
    logic                       res_fire;

    assign res_fire = active && res_ready;
    assign last_word = ({1'b0, rd_index} == read.length - 1'b1);

    always_ff @(posedge clock) begin
        if (reset) begin
            active <= 1'b0;
            rd_index <= '0;
            release_q <= 1'b0;
        end else begin
            release_q <= 1'b0;
            if (read.sorted) begin
                active <= 1'b1;
                rd_index <= '0;
            end else if (res_fire) begin
                if (last_word) begin
                    active <= 1'b0;
                    release_q <= 1'b1;
                end else begin
                    rd_index <= rd_index + 1'b1;
                end
            end
        end
    end

    // the index only moves on a transfer, so the word stays put while res_ready is low
    assign read.rd_index = rd_index;
    assign read.release_pulse = release_q;

    assign res_valid = active;
    assign res_data = read.rd_data;
    assign res_dest = read.dest;
    assign res_last = last_word;

endmodule

// ==== efi_sort_engine.sv ====
// efi_sort_engine: batch storage and odd-even transposition sort over the loaded words

`timescale 1ns/1ps
`include "efi_sorter_macros.svh"

module efi_sort_engine (
    input  logic        clock,
    input  logic        reset,
    efi_load_if.engine  load,
    efi_read_if.engine  read
);

    efi_sorter_pkg::efi_word_t   storage [`EFI_MAX_LENGTH];
    efi_sorter_pkg::efi_word_t   phase_result [`EFI_MAX_LENGTH];
    efi_sorter_pkg::efi_length_t length_q;
    efi_sorter_pkg::efi_dest_t   dest_q;
    // counts the transposition phases already done, bit zero picks even or odd pairs
    efi_sorter_pkg::efi_length_t phase;
    logic                        sorting;
    logic                        sorted_q;
    logic                        busy_q;

    // one compare-and-swap phase over the first length_q entries
    always_comb begin
        phase_result = storage;
        for (int i = 0; i < `EFI_MAX_LENGTH - 1; i++) begin
            if (((i % 2) == int'(phase[0])) && ((i + 1) < int'(length_q))) begin
                if (storage[i] > storage[i + 1]) begin
                    phase_result[i] = storage[i + 1];
                    phase_result[i + 1] = storage[i];
                end
            end
        end
    end

    // the decoder only writes while the engine is idle, so the two never collide
    always_ff @(posedge clock) begin
        if (load.wr_en) begin
            storage[load.wr_index] <= load.wr_data;
        end else if (sorting) begin
            storage <= phase_result;
        end
    end

    always_ff @(posedge clock) begin
        if (load.start) begin
            length_q <= load.length;
            dest_q <= load.dest;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            busy_q <= 1'b0;
            sorting <= 1'b0;
            sorted_q <= 1'b0;
            phase <= '0;
        end else begin
            sorted_q <= 1'b0;
            if (load.start) begin
                busy_q <= 1'b1;
                sorting <= 1'b1;
                phase <= '0;
            end else if (sorting) begin
                // a batch of n words is fully ordered after n phases
                if (phase == length_q - 1'b1) begin
                    sorting <= 1'b0;
                    sorted_q <= 1'b1;
                end else begin
                    phase <= phase + 1'b1;
                end
            end
            if (read.release_pulse) begin
                busy_q <= 1'b0;
            end
        end
    end

    assign load.busy = busy_q;

    assign read.sorted = sorted_q;
    assign read.length = length_q;
    assign read.dest = dest_q;
    assign read.rd_data = storage[read.rd_index];

endmodule

// ==== efi_sorter.sv ====
// efi_sorter: top level of the sorting accelerator joining decoder, sort engine and streamer

`timescale 1ns/1ps

module efi_sorter (
    input  logic                      clock,
    input  logic                      reset,

    // argument stream from the core
    input  logic                      arg_valid,
    output logic                      arg_ready,
    input  efi_sorter_pkg::efi_word_t arg_data,
    input  efi_sorter_pkg::efi_dest_t arg_dest,
    input  logic                      arg_last,

    // sorted result stream back to the core
    output logic                      res_valid,
    input  logic                      res_ready,
    output efi_sorter_pkg::efi_word_t res_data,
    output efi_sorter_pkg::efi_dest_t res_dest,
    output logic                      res_last
);

    efi_load_if load_bus ();
    efi_read_if read_bus ();

    efi_argument_decoder decoder0 (
        .clock(clock),
        .reset(reset),
        .arg_valid(arg_valid),
        .arg_ready(arg_ready),
        .arg_data(arg_data),
        .arg_dest(arg_dest),
        .arg_last(arg_last),
        .load(load_bus)
    );

    efi_sort_engine engine0 (
        .clock(clock),
        .reset(reset),
        .load(load_bus),
        .read(read_bus)
    );

    efi_result_streamer streamer0 (
        .clock(clock),
        .reset(reset),
        .read(read_bus),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res_data(res_data),
        .res_dest(res_dest),
        .res_last(res_last)
    );

endmodule

// ==== efi_sorter_checker.sv ====
// efi_sorter_checker: reference model of the sorter that compares every result transfer

`timescale 1ns/1ps
`include "efi_sorter_macros.svh"

module efi_sorter_checker (
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      arg_valid,
    input  logic                      arg_ready,
    input  efi_sorter_pkg::efi_word_t arg_data,
    input  efi_sorter_pkg::efi_dest_t arg_dest,
    input  logic                      arg_last,
    input  logic                      res_valid,
    input  logic                      res_ready,
    input  efi_sorter_pkg::efi_word_t res_data,
    input  efi_sorter_pkg::efi_dest_t res_dest,
    input  logic                      res_last,
    output int                        mismatch_count,
    output int                        other_count,
    output int                        pending_batches
);

    // the first EFI_MAX_LENGTH words of the batch that is still arriving
    efi_sorter_pkg::efi_word_t batch_words [$];
    efi_sorter_pkg::efi_dest_t batch_dest;
    int                        batch_count = 0;

    // expected result transfers of all batches in send order
    efi_sorter_pkg::efi_word_t exp_data [$];
    efi_sorter_pkg::efi_dest_t exp_dest [$];
    logic                      exp_last [$];

    int mismatches = 0;
    int others = 0;
    int batches_sent = 0;
    int batches_returned = 0;

    // state of the result channel at the previous sample
    logic                      holding = 1'b0;
    logic                      after_reset = 1'b0;
    efi_sorter_pkg::efi_word_t held_data;
    efi_sorter_pkg::efi_dest_t held_dest;
    logic                      held_last;

    assign mismatch_count = mismatches;
    assign other_count = others;
    assign pending_batches = batches_sent - batches_returned;

    // sort the finished batch by insertion and queue it as expected results
    task automatic queue_sorted_batch();
        efi_sorter_pkg::efi_word_t words [$];
        efi_sorter_pkg::efi_word_t key;
        int j;
        words = batch_words;
        for (int i = 1; i < words.size(); i++) begin
            key = words[i];
            j = i - 1;
            while (j >= 0 && words[j] > key) begin
                words[j + 1] = words[j];
                j--;
            end
            words[j + 1] = key;
        end
        for (int i = 0; i < words.size(); i++) begin
            exp_data.push_back(words[i]);
            exp_dest.push_back(batch_dest);
            exp_last.push_back(i == words.size() - 1);
        end
        batches_sent++;
    endtask

    task automatic record_argument();
        if (batch_count == 0) begin
            batch_dest = arg_dest;
        end
        if (batch_count < `EFI_MAX_LENGTH) begin
            batch_words.push_back(arg_data);
        end
        batch_count++;
        if (arg_last) begin
            queue_sorted_batch();
            batch_words.delete();
            batch_count = 0;
        end
    endtask

    task automatic check_result();
        efi_sorter_pkg::efi_word_t data;
        efi_sorter_pkg::efi_dest_t dest;
        logic last;
        if (exp_data.size() == 0) begin
            $display("ERROR at %0t: result word %h arrived with no batch pending", $time, res_data);
            others++;
        end else begin
            data = exp_data.pop_front();
            dest = exp_dest.pop_front();
            last = exp_last.pop_front();
            if (res_data !== data) begin
                $display("MISMATCH at %0t: res_data %h, expected %h", $time, res_data, data);
                mismatches++;
            end
            if (res_dest !== dest) begin
                $display("MISMATCH at %0t: res_dest %h, expected %h", $time, res_dest, dest);
                mismatches++;
            end
            if (res_last !== last) begin
                $display("MISMATCH at %0t: res_last %b, expected %b", $time, res_last, last);
                mismatches++;
            end
            if (last) begin
                batches_returned++;
            end
        end
    endtask

    // inputs change just after the rising edge, so the falling edge sees settled values
    always @(negedge clock) begin
        if (reset) begin
            if (res_valid !== 1'b0) begin
                $display("MISMATCH at %0t: res_valid %b during reset, expected 0", $time,
                         res_valid);
                mismatches++;
            end
            after_reset = 1'b1;
            holding = 1'b0;
        end else begin
            if (after_reset && res_valid !== 1'b0) begin
                $display("MISMATCH at %0t: res_valid %b right after reset, expected 0", $time,
                         res_valid);
                mismatches++;
            end
            if (after_reset && arg_ready !== 1'b1) begin
                $display("MISMATCH at %0t: arg_ready %b right after reset, expected 1", $time,
                         arg_ready);
                mismatches++;
            end
            after_reset = 1'b0;
            // the storage stays with the engine until its batch has fully come back
            if (batches_sent != batches_returned && arg_ready !== 1'b0) begin
                $display("MISMATCH at %0t: arg_ready %b while a batch is in flight, expected 0",
                         $time, arg_ready);
                mismatches++;
            end
            if (holding && (res_valid !== 1'b1 || res_data !== held_data
                    || res_dest !== held_dest || res_last !== held_last)) begin
                $display("MISMATCH at %0t: result word changed while res_ready was low", $time);
                mismatches++;
            end
            if (arg_valid && arg_ready) begin
                record_argument();
            end
            if (res_valid && res_ready) begin
                check_result();
            end
            holding = res_valid && !res_ready;
            held_data = res_data;
            held_dest = res_dest;
            held_last = res_last;
        end
    end

endmodule

// ==== efi_sorter_ifs.sv ====
// internal interfaces efi_load_if (decoder to engine) and efi_read_if (engine to streamer)

`timescale 1ns/1ps

interface efi_load_if;
    logic                       wr_en;
    efi_sorter_pkg::efi_index_t wr_index;
    efi_sorter_pkg::efi_word_t  wr_data;
    logic                       start;
    efi_sorter_pkg::efi_length_t length;
    efi_sorter_pkg::efi_dest_t  dest;
    logic                       busy;

    modport decoder (output wr_en, wr_index, wr_data, start, length, dest, input busy);
    modport engine (input wr_en, wr_index, wr_data, start, length, dest, output busy);
endinterface

interface efi_read_if;
    logic                        sorted;
    efi_sorter_pkg::efi_length_t length;
    efi_sorter_pkg::efi_dest_t   dest;
    efi_sorter_pkg::efi_word_t   rd_data;
    efi_sorter_pkg::efi_index_t  rd_index;
    // one-cycle pulse that hands the storage back once the last result word has left
    logic                        release_pulse;

    modport engine (output sorted, length, dest, rd_data, input rd_index, release_pulse);
    modport streamer (input sorted, length, dest, rd_data, output rd_index, release_pulse);
endinterface

// ==== efi_sorter_macros.svh ====
// width and size macros for the sorting accelerator: data word, destination tag, batch storage

`ifndef EFI_SORTER_MACROS_SVH
`define EFI_SORTER_MACROS_SVH

// width of one sorted word in bits
`define EFI_DATA_WIDTH 32

// width of the destination tag that travels with each batch
`define EFI_DEST_WIDTH 8

// number of words one batch can hold, any power of two works
`define EFI_MAX_LENGTH 16

// address width into the batch storage
`define EFI_INDEX_WIDTH $clog2(`EFI_MAX_LENGTH)

`endif

// ==== efi_sorter_pkg.sv ====
// shared types of the sorting accelerator: word, destination, storage index and batch length

`include "efi_sorter_macros.svh"

package efi_sorter_pkg;

    // one unsigned data word as it travels on both streams
    typedef logic [`EFI_DATA_WIDTH-1:0] efi_word_t;

    // destination tag carried by the argument and result streams
    typedef logic [`EFI_DEST_WIDTH-1:0] efi_dest_t;

    // address of one slot in the batch storage
    typedef logic [`EFI_INDEX_WIDTH-1:0] efi_index_t;

    // batch length from zero up to the full storage size, so one bit wider than the index
    typedef logic [`EFI_INDEX_WIDTH:0] efi_length_t;

endpackage

// ==== filelist.f ====
+incdir+.
efi_sorter_pkg.sv
efi_sorter_ifs.sv
efi_argument_decoder.sv
efi_sort_engine.sv
efi_result_streamer.sv
efi_sorter.sv
efi_sorter_checker.sv
tb_efi_sorter.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the sorter testbench with Verilator, run it and scan the log for a failure.
set -e

cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_efi_sorter -f filelist.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without a failure"

// ==== tb_efi_sorter.sv ====
// tb_efi_sorter: clock, reset, random batch stimulus, result back-pressure, watchdog and report

`timescale 1ns/1ps
`include "efi_sorter_macros.svh"

module tb_efi_sorter;

    localparam int CLOCK_PERIOD = 100;
    localparam int BATCHES = 40;
    localparam int MAX_BATCH = 20;
    localparam int WATCHDOG_CYCLES = BATCHES * (MAX_BATCH + 2 * MAX_BATCH + 10) * 4;

    logic                      clock = 1'b0;
    logic                      reset;
    logic                      arg_valid;
    logic                      arg_ready;
    efi_sorter_pkg::efi_word_t arg_data;
    efi_sorter_pkg::efi_dest_t arg_dest;
    logic                      arg_last;
    logic                      res_valid;
    logic                      res_ready;
    efi_sorter_pkg::efi_word_t res_data;
    efi_sorter_pkg::efi_dest_t res_dest;
    logic                      res_last;
    int                        mismatch_count;
    int                        other_count;
    int                        pending_batches;
    logic [31:0]               lfsr_state;

    efi_sorter dut0 (
        .clock(clock),
        .reset(reset),
        .arg_valid(arg_valid),
        .arg_ready(arg_ready),
        .arg_data(arg_data),
        .arg_dest(arg_dest),
        .arg_last(arg_last),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res_data(res_data),
        .res_dest(res_dest),
        .res_last(res_last)
    );

    efi_sorter_checker checker0 (
        .clock(clock),
        .reset(reset),
        .arg_valid(arg_valid),
        .arg_ready(arg_ready),
        .arg_data(arg_data),
        .arg_dest(arg_dest),
        .arg_last(arg_last),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res_data(res_data),
        .res_dest(res_dest),
        .res_last(res_last),
        .mismatch_count(mismatch_count),
        .other_count(other_count),
        .pending_batches(pending_batches)
    );

    always #(CLOCK_PERIOD / 2) clock = ~clock;

    // right-shifting Galois LFSR for x^32 + x^30 + x^26 + x^25 + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hA300_0000;
        end
        return state >> 1;
    endfunction

    task automatic draw_bits(input int width, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < width; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // moves to just after the next rising edge and reports whether the argument word went in
    task automatic advance_cycle(output logic accepted);
        logic [31:0] pick;
        @(negedge clock);
        accepted = arg_valid && arg_ready;
        @(posedge clock);
        #1;
        draw_bits(8, pick);
        // about one cycle in three holds the result stream back
        res_ready = (pick >= 32'd85);
    endtask

    task automatic send_batch(input int length, input efi_sorter_pkg::efi_dest_t dest,
                              input logic narrow);
        logic [31:0] value;
        logic [31:0] idle;
        logic accepted;
        for (int w = 0; w < length; w++) begin
            draw_bits(2, idle);
            if (idle == 0) begin
                arg_valid = 1'b0;
                advance_cycle(accepted);
            end
            draw_bits(narrow ? 3 : 32, value);
            arg_valid = 1'b1;
            arg_data = value;
            arg_dest = dest;
            arg_last = (w == length - 1);
            accepted = 1'b0;
            while (!accepted) begin
                advance_cycle(accepted);
            end
        end
        arg_valid = 1'b0;
        arg_last = 1'b0;
    endtask

    initial begin
        logic [31:0] pick;
        logic [31:0] dest;
        logic accepted;
        int length;
        lfsr_state = 32'he74a461e;
        reset = 1'b1;
        arg_valid = 1'b0;
        arg_data = '0;
        arg_dest = '0;
        arg_last = 1'b0;
        res_ready = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        reset = 1'b0;
        for (int b = 0; b < BATCHES; b++) begin
            draw_bits(5, pick);
            length = int'(pick % MAX_BATCH) + 1;
            // a single word and an overlong batch are always part of the run
            if (b == 0) length = 1;
            if (b == 1) length = MAX_BATCH;
            draw_bits(8, dest);
            draw_bits(2, pick);
            send_batch(length, dest[7:0], pick == 0);
        end
        while (pending_batches != 0) begin
            advance_cycle(accepted);
        end
        // a quiet tail shows up stray result words
        repeat (20) advance_cycle(accepted);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLOCK_PERIOD);
        $display("timeout after %0d cycles with %0d batches never returned", WATCHDOG_CYCLES,
                 pending_batches);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        $display("*** FAILED ***");
        $finish;
    end

endmodule
